/* all.f */
rtl/icache_cfg_pkg.sv
rtl/icache_types_pkg.sv
rtl/refill_if.sv
rtl/register_file_1r_1w.sv
rtl/ram_ws_rs_data_scm.sv
rtl/ram_ws_rs_tag_scm.sv
rtl/icache_ctrl.sv
rtl/icache_refill.sv
rtl/icache_top.sv
dv/tb_clk_gen.sv
dv/icache_checker.sv
dv/icache_tb.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := icache_tb
FILELIST := all.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/icache_tb.sv */
/*
 * Top of the instruction cache testbench.
 * Resets the DUT, runs a directed eviction and flush sequence, then
 * random fetches from a small pool of lines with random back-pressure.
 * Models the refill memory with random stalls; the checker compares.
 */
`timescale 1ns/100ps

module icache_tb import icache_cfg_pkg::*; ();

    localparam int NUM_FETCHES = 300;
    localparam int WAIT_LIMIT  = 200;    // Cycles allowed per wait

    logic              clk;
    logic              arst_n;
    logic              fetch_valid;
    logic              fetch_ready;
    logic [ADDR_W-1:0] fetch_addr;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_data;
    logic              flush;
    logic              mem_req_valid;
    logic              mem_req_ready = 1'b0;   // Memory side starts quiet
    logic [ADDR_W-1:0] mem_req_addr;
    logic              mem_rsp_valid = 1'b0;
    logic [DATA_W-1:0] mem_rsp_data  = '0;

    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng = 32'hfedb;
    logic [ADDR_W-1:0] beat_addr;
    int                beats_left = 0;
    logic              timed_out;
    int                timeout_count;
    int                fetch_count;
    int                check_count;
    int                error_count;
    int                hit_count;
    int                miss_count;

    tb_clk_gen #(.PERIOD_NS(100)) clk_gen_i (.clk(clk));

    icache_top dut_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .fetch_valid   ( fetch_valid   ),
        .fetch_ready   ( fetch_ready   ),
        .fetch_addr    ( fetch_addr    ),
        .rsp_valid     ( rsp_valid     ),
        .rsp_ready     ( rsp_ready     ),
        .rsp_data      ( rsp_data      ),
        .flush         ( flush         ),
        .mem_req_valid ( mem_req_valid ),
        .mem_req_ready ( mem_req_ready ),
        .mem_req_addr  ( mem_req_addr  ),
        .mem_rsp_valid ( mem_rsp_valid ),
        .mem_rsp_data  ( mem_rsp_data  )
    );

    icache_checker chk_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .fetch_valid   ( fetch_valid   ),
        .fetch_ready   ( fetch_ready   ),
        .fetch_addr    ( fetch_addr    ),
        .rsp_valid     ( rsp_valid     ),
        .rsp_ready     ( rsp_ready     ),
        .rsp_data      ( rsp_data      ),
        .flush         ( flush         ),
        .mem_req_valid ( mem_req_valid ),
        .mem_req_ready ( mem_req_ready ),
        .mem_req_addr  ( mem_req_addr  ),
        .check_count   ( check_count   ),
        .error_count   ( error_count   ),
        .hit_count     ( hit_count     ),
        .miss_count    ( miss_count    )
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Four tags, so sets are shared and lines get evicted
    function automatic logic [ADDR_W-1:0] make_addr(input logic [1:0] tag_idx,
                                                     input logic [SET_W-1:0] set,
                                                     input logic [WORD_W-1:0] word);
        logic [TAG_W-1:0] tag;
        case (tag_idx)
            2'd0:    tag = 24'h00_0040;
            2'd1:    tag = 24'h00_1f00;
            2'd2:    tag = 24'h7c_0a11;
            default: tag = 24'hff_ffe0;
        endcase
        return {tag, set, word, 2'b00};
    endfunction

    // Memory latches the line address and streams four beats
    always @(posedge clk) begin
        if (!arst_n) begin
            beats_left <= 0;
        end else if (mem_req_valid && mem_req_ready) begin
            beat_addr  <= mem_req_addr;                 // Word 0 first
            beats_left <= LINE_WORDS;
        end else if (mem_rsp_valid) begin
            beat_addr  <= beat_addr + 32'd4;
            beats_left <= beats_left - 1;
        end
    end

    always @(negedge clk) begin
        mem_rng       = lcg_next(mem_rng);
        mem_req_ready = mem_rng[17] | mem_rng[23];      // Ready about 3/4 of cycles
        if (beats_left > 0 && mem_rng[26:25] != 2'b00) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = chk_i.word_hash(beat_addr);
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp_data  = mem_rng;                    // Junk between beats
        end
    end

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        timeout_count++;
        $display("Timeout: no %s within %0d cycles at %0t", what, WAIT_LIMIT, $time);
    endtask

    // One fetch, from request to response handshake
    task automatic fetch_word(input logic [ADDR_W-1:0] addr);
        int   waited;
        logic done;
        if (timed_out) return;
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        waited      = 0;
        done        = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            @(posedge clk);
            if (fetch_ready) done = 1'b1;
            else waited++;
        end
        if (!done) begin
            report_timeout("fetch acceptance");
            return;
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        waited      = 0;
        done        = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
            stim_rng  = lcg_next(stim_rng);
            rsp_ready = stim_rng[29] | stim_rng[27];    // Random back-pressure
            @(posedge clk);
            if (rsp_valid && rsp_ready) begin
                done = 1'b1;
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        if (!done) report_timeout("response");
        else fetch_count++;
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        int                gap;
        arst_n        = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        rsp_ready     = 1'b0;
        flush         = 1'b0;
        stim_rng      = 32'hfedb;
        timed_out     = 1'b0;
        timeout_count = 0;
        fetch_count   = 0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        fetch_word(make_addr(2'd0, 4'h5, 2'd1));   // Cold miss
        fetch_word(make_addr(2'd0, 4'h5, 2'd3));   // Same line
        fetch_word(make_addr(2'd2, 4'h5, 2'd0));   // Conflict in set 5
        fetch_word(make_addr(2'd0, 4'h5, 2'd1));   // Evicted, misses again
        fetch_word(make_addr(2'd1, 4'h9, 2'd2));
        pulse_flush();
        fetch_word(make_addr(2'd0, 4'h5, 2'd1));   // Both lines gone after flush
        fetch_word(make_addr(2'd1, 4'h9, 2'd2));

        while (fetch_count < NUM_FETCHES && !timed_out) begin
            stim_rng = lcg_next(stim_rng);
            gap      = int'(stim_rng[31:30]);
            repeat (gap) @(negedge clk);
            if (stim_rng[28:24] == 5'd0) pulse_flush();   // Rare
            addr = make_addr(stim_rng[21:20], {2'b00, stim_rng[19:18]}, stim_rng[17:16]);
            fetch_word(addr);
        end

        repeat (4) @(negedge clk);
        $display("Summary: %0d fetches, %0d hits, %0d misses, %0d checks, %0d errors, %0d timeouts",
                 fetch_count, hit_count, miss_count, check_count, error_count, timeout_count);
        if (timed_out || error_count != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

/* dv/icache_checker.sv */
/*
 * Scoreboard for the instruction cache.
 * Samples the DUT ports on each rising edge, keeps its own tag and
 * valid state per set and checks hit/miss behavior, refill requests,
 * response data and back-pressure. word_hash gives the memory contents.
 */
`timescale 1ns/100ps

module icache_checker
    import icache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              fetch_valid,
    input  logic              fetch_ready,
    input  logic [ADDR_W-1:0] fetch_addr,
    input  logic              rsp_valid,
    input  logic              rsp_ready,
    input  logic [DATA_W-1:0] rsp_data,
    input  logic              flush,
    input  logic              mem_req_valid,
    input  logic              mem_req_ready,
    input  logic [ADDR_W-1:0] mem_req_addr,
    output int                check_count,
    output int                error_count,
    output int                hit_count,
    output int                miss_count
);

    logic              model_valid [NUM_SETS];   // Expected cache state
    logic [TAG_W-1:0]  model_tag   [NUM_SETS];
    logic [ADDR_W-1:0] cur_addr;                 // Fetch in flight
    logic              busy = 1'b0;
    logic              exp_hit;
    logic              stalled = 1'b0;           // Response held last edge
    logic [DATA_W-1:0] held_data;
    int                age;                      // Edges since acceptance
    int                req_seen;
    int                checks = 0;
    int                errors = 0;
    int                hits   = 0;
    int                misses = 0;

    assign check_count = checks;
    assign error_count = errors;
    assign hit_count   = hits;
    assign miss_count  = misses;

    // Memory contents as a hash of the whole byte address
    function automatic logic [DATA_W-1:0] word_hash(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ {h[15:0], h[31:16]} ^ a;
        return h ^ 32'h5bd1_e995;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_unexpected(input string what);
        errors++;
        $display("Unexpected %s at %0t", what, $time);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) model_valid[s] = 1'b0;
            busy    = 1'b0;
            stalled = 1'b0;
        end else begin
            // Stalled response keeps valid and word
            if (stalled) begin
                check_value("stall_rsp_valid", 32'd1, 32'(rsp_valid));
                check_value("stall_rsp_data", held_data, rsp_data);
            end
            stalled   = rsp_valid && !rsp_ready;
            held_data = rsp_data;

            if (mem_req_valid && mem_req_ready) begin
                if (!busy) begin
                    report_unexpected("memory request with no fetch in flight");
                end else begin
                    req_seen++;
                    check_value("mem_req_addr",
                                {cur_addr[ADDR_W-1:WORD_W+2], {(WORD_W+2){1'b0}}},
                                mem_req_addr);
                end
            end

            // Flush only lands while idle
            if (flush && !busy) begin
                for (int s = 0; s < NUM_SETS; s++) model_valid[s] = 1'b0;
            end

            if (busy) begin
                age++;
                check_value("fetch_ready_while_busy", 32'd0, 32'(fetch_ready));  // One at a time
                if (age == 1) begin
                    if (exp_hit) check_value("hit_rsp_latency", 32'd1, 32'(rsp_valid));
                    else check_value("miss_no_early_rsp", 32'd0, 32'(rsp_valid));
                end
                if (rsp_valid && rsp_ready) begin
                    check_value("rsp_data", word_hash(cur_addr), rsp_data);
                    check_value("mem_req_count", exp_hit ? 32'd0 : 32'd1, 32'(req_seen));
                    busy = 1'b0;
                end
            end else if (rsp_valid) begin
                report_unexpected("response with no fetch in flight");
            end

            if (fetch_valid && fetch_ready) begin
                cur_addr = fetch_addr;
                exp_hit  = model_valid[cur_addr[WORD_W+2 +: SET_W]]
                        && (model_tag[cur_addr[WORD_W+2 +: SET_W]]
                            == cur_addr[ADDR_W-1 -: TAG_W]);
                if (exp_hit) begin
                    hits++;
                end else begin
                    misses++;                                  // Line replaces the set
                    model_valid[cur_addr[WORD_W+2 +: SET_W]] = 1'b1;
                    model_tag[cur_addr[WORD_W+2 +: SET_W]]   = cur_addr[ADDR_W-1 -: TAG_W];
                end
                busy     = 1'b1;
                age      = 0;
                req_seen = 0;
            end
        end
    end

endmodule

/* dv/tb_clk_gen.sv */
/*
 * Free-running testbench clock, starts low.
 * Default period is 100 ns.
 */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // Half period per phase
    end

endmodule

/* rtl/icache_top.sv */
/*
 * Top level of the read-only instruction cache.
 * Fetch port in, response port out, one memory port for line refills
 * and a flush input that invalidates all lines. Wiring only.
 */
`timescale 1ns/100ps

module icache_top
    import icache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    input  logic              fetch_valid,
    output logic              fetch_ready,
    input  logic [ADDR_W-1:0] fetch_addr,

    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_data,

    input  logic              flush,

    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic [ADDR_W-1:0] mem_req_addr,
    input  logic              mem_rsp_valid,
    input  logic [DATA_W-1:0] mem_rsp_data
);

    // Data array port
    logic [DATA_RAM_AW-1:0] data_addr;
    logic                   data_req;
    logic                   data_write;
    logic [DATA_W-1:0]      data_wdata;
    logic [DATA_W-1:0]      data_rdata;

    // Tag array port
    logic [SET_W-1:0]       tag_set;
    logic                   tag_req;
    logic                   tag_write;
    logic [TAG_W-1:0]       tag_wtag;
    logic                   tag_flush_all;
    logic [TAG_W-1:0]       tag_rtag;
    logic                   tag_rvalid;

    refill_if refill_bus ();

    icache_ctrl ctrl_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .fetch_valid   ( fetch_valid   ),
        .fetch_ready   ( fetch_ready   ),
        .fetch_addr    ( fetch_addr    ),
        .rsp_valid     ( rsp_valid     ),
        .rsp_ready     ( rsp_ready     ),
        .rsp_data      ( rsp_data      ),
        .flush         ( flush         ),
        .rbus          ( refill_bus    ),
        .data_addr     ( data_addr     ),
        .data_req      ( data_req      ),
        .data_write    ( data_write    ),
        .data_wdata    ( data_wdata    ),
        .data_rdata    ( data_rdata    ),
        .tag_set       ( tag_set       ),
        .tag_req       ( tag_req       ),
        .tag_write     ( tag_write     ),
        .tag_wtag      ( tag_wtag      ),
        .tag_flush_all ( tag_flush_all ),
        .tag_rtag      ( tag_rtag      ),
        .tag_rvalid    ( tag_rvalid    )
    );

    icache_refill refill_i (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .rbus          ( refill_bus    ),
        .mem_req_valid ( mem_req_valid ),
        .mem_req_ready ( mem_req_ready ),
        .mem_req_addr  ( mem_req_addr  ),
        .mem_rsp_valid ( mem_rsp_valid ),
        .mem_rsp_data  ( mem_rsp_data  )
    );

    ram_ws_rs_data_scm data_ram_i (
        .clk    ( clk        ),
        .arst_n ( arst_n     ),
        .addr   ( data_addr  ),
        .req    ( data_req   ),
        .write  ( data_write ),
        .wdata  ( data_wdata ),
        .rdata  ( data_rdata )
    );

    ram_ws_rs_tag_scm tag_ram_i (
        .clk       ( clk           ),
        .arst_n    ( arst_n        ),
        .set       ( tag_set       ),
        .req       ( tag_req       ),
        .write     ( tag_write     ),
        .wtag      ( tag_wtag      ),
        .flush_all ( tag_flush_all ),
        .rtag      ( tag_rtag      ),
        .rvalid    ( tag_rvalid    )
    );

endmodule

/* rtl/icache_refill.sv */
/*
 * Refill unit of the instruction cache.
 * Takes a line address from the controller, issues one line-aligned
 * request on the memory port and forwards the four returning beats,
 * word 0 first. done pulses in the cycle after the last beat.
 */
`timescale 1ns/100ps

module icache_refill
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    refill_if.refill          rbus,

    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output logic [ADDR_W-1:0] mem_req_addr,
    input  logic              mem_rsp_valid,
    input  logic [DATA_W-1:0] mem_rsp_data
);

    enum logic [1:0] {PH_IDLE, PH_REQ, PH_BEAT, PH_DONE} phase_q, phase_d;

    logic [WORD_W-1:0]   beat_q;     // Next word expected
    icache_addr_fields_t line_f;     // Line-aligned request address
    logic                start;
    logic                last_beat;

    // Clear word and byte bits of the miss address
    always_comb begin
        line_f        = rbus.line_addr.f;
        line_f.word   = '0;
        line_f.offset = '0;
    end

    assign mem_req_addr  = line_f;
    assign mem_req_valid = (phase_q == PH_REQ);   // Held until accepted

    assign rbus.start_ready = (phase_q == PH_IDLE);
    assign start            = rbus.start_valid && rbus.start_ready;

    // Beats pass straight through to the data array
    assign rbus.word_valid = (phase_q == PH_BEAT) && mem_rsp_valid;
    assign rbus.word_idx   = beat_q;
    assign rbus.word_data  = mem_rsp_data;
    assign rbus.done       = (phase_q == PH_DONE);

    assign last_beat = rbus.word_valid && (beat_q == WORD_W'(LINE_WORDS - 1));

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (start) begin
                    phase_d = PH_REQ;
                end
            end
            PH_REQ: begin
                if (mem_req_ready) begin
                    phase_d = PH_BEAT;
                end
            end
            PH_BEAT: begin
                if (last_beat) begin
                    phase_d = PH_DONE;
                end
            end
            default: phase_d = PH_IDLE;   // Done lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_q <= '0;
        end else if (start) begin
            beat_q <= '0;                 // Each burst starts at word 0
        end else if (rbus.word_valid) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // Memory only answers an accepted request, and only four times
    rsp_in_beat_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp_valid |-> phase_q == PH_BEAT);

endmodule

/* rtl/icache_ctrl.sv */
/*
 * Lookup controller of the instruction cache.
 * Accepts one fetch at a time, reads tag and data in parallel and
 * answers a hit on the next cycle. A miss writes the new tag, lets
 * the refill unit stream the line in, then replays the data read.
 */
`timescale 1ns/100ps

module icache_ctrl
    import icache_cfg_pkg::*;
    import icache_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  logic [ADDR_W-1:0]      fetch_addr,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [DATA_W-1:0]      rsp_data,
    input  logic                   flush,

    refill_if.ctrl                 rbus,

    output logic [DATA_RAM_AW-1:0] data_addr,
    output logic                   data_req,
    output logic                   data_write,
    output logic [DATA_W-1:0]      data_wdata,
    input  logic [DATA_W-1:0]      data_rdata,

    output logic [SET_W-1:0]       tag_set,
    output logic                   tag_req,
    output logic                   tag_write,
    output logic [TAG_W-1:0]       tag_wtag,
    output logic                   tag_flush_all,
    input  logic [TAG_W-1:0]       tag_rtag,
    input  logic                   tag_rvalid
);

    enum logic [2:0] {IDLE, LOOKUP, REFILL, REPLAY, RESPOND} state_q, state_d;

    icache_addr_t fetch_dec;   // Incoming address, split into fields
    icache_addr_t addr_q;      // Fetch in flight
    logic         accept;
    logic         hit;
    logic         start;       // Refill handshake

    assign fetch_dec.flat = fetch_addr;

    assign fetch_ready = (state_q == IDLE) && !flush;   // Flush wins over fetch
    assign accept      = fetch_valid && fetch_ready;
    assign hit         = tag_rvalid && (tag_rtag == addr_q.f.tag);

    assign rbus.start_valid = (state_q == LOOKUP) && !hit;
    assign rbus.line_addr   = addr_q;
    assign start            = rbus.start_valid && rbus.start_ready;

    // Hit answers straight from the lookup cycle
    assign rsp_valid = ((state_q == LOOKUP) && hit) || (state_q == RESPOND);
    assign rsp_data  = data_rdata;   // Held by the array while no read is issued

    // Tag read on accept, tag write when the refill starts
    assign tag_set       = (state_q == IDLE) ? fetch_dec.f.set : addr_q.f.set;
    assign tag_req       = accept || start;
    assign tag_write     = (state_q == LOOKUP);
    assign tag_wtag      = addr_q.f.tag;
    assign tag_flush_all = (state_q == IDLE) && flush;

    // Data index from the new fetch, a refill beat or the replay
    always_comb begin
        case (state_q)
            IDLE:    data_addr = {fetch_dec.f.set, fetch_dec.f.word};
            REFILL:  data_addr = {addr_q.f.set, rbus.word_idx};
            default: data_addr = {addr_q.f.set, addr_q.f.word};
        endcase
    end

    assign data_req   = accept || (state_q == REPLAY)
                     || ((state_q == REFILL) && rbus.word_valid);
    assign data_write = (state_q == REFILL);
    assign data_wdata = rbus.word_data;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = rsp_ready ? IDLE : RESPOND;
                end else if (start) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (rbus.done) begin
                    state_d = REPLAY;
                end
            end
            REPLAY:  state_d = RESPOND;       // Read of the requested word
            RESPOND: begin
                if (rsp_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= fetch_dec;
        end
    end

    // Stalled response keeps its word until taken
    rsp_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

/* rtl/ram_ws_rs_tag_scm.sv */
/*
 * Tag store of the cache with one valid bit per set.
 * A write stores the tag and marks its set valid; flush_all
 * invalidates every set. rtag and rvalid follow a read by one cycle.
 */
`timescale 1ns/100ps

module ram_ws_rs_tag_scm
    import icache_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic [SET_W-1:0] set,
    input  logic             req,
    input  logic             write,
    input  logic [TAG_W-1:0] wtag,
    input  logic             flush_all,
    output logic [TAG_W-1:0] rtag,
    output logic             rvalid
);

    logic [NUM_SETS-1:0] valid_q;   // Per-set valid bits
    logic                read_en;
    logic                write_en;

    assign read_en  = req & ~write;
    assign write_en = req & write;

    register_file_1r_1w #(
        .ADDR_WIDTH ( SET_W ),
        .DATA_WIDTH ( TAG_W )
    ) scm_tag (
        .clk          ( clk      ),
        .read_enable  ( read_en  ),
        .read_addr    ( set      ),
        .read_data    ( rtag     ),
        .write_enable ( write_en ),
        .write_addr   ( set      ),
        .write_data   ( wtag     )
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush_all) begin
            valid_q <= '0;              // Invalidate all lines
        end else if (write_en) begin
            valid_q[set] <= 1'b1;
        end
    end

    // Valid bit sampled with the tag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (read_en) begin
            rvalid <= valid_q[set];
        end
    end

    // Flush is only taken while no fetch is being looked up
    flush_no_req_a: assert property (@(posedge clk) disable iff (!arst_n)
        flush_all |-> !req);

endmodule

/* rtl/ram_ws_rs_data_scm.sv */
/*
 * Data store of the cache, one word per set and word index.
 * Single request port: req with write low reads, req with write
 * high writes a whole word. Read data appears the cycle after req.
 */
`timescale 1ns/100ps

module ram_ws_rs_data_scm
    import icache_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [DATA_RAM_AW-1:0] addr,
    input  logic                   req,
    input  logic                   write,
    input  logic [DATA_W-1:0]      wdata,
    output logic [DATA_W-1:0]      rdata
);

    logic read_en;
    logic write_en;

    assign read_en  = req & ~write;  // Read request
    assign write_en = req & write;   // Refill word

    register_file_1r_1w #(
        .ADDR_WIDTH ( DATA_RAM_AW ),
        .DATA_WIDTH ( DATA_W      )
    ) scm_data (
        .clk          ( clk      ),
        .read_enable  ( read_en  ),
        .read_addr    ( addr     ),
        .read_data    ( rdata    ),
        .write_enable ( write_en ),
        .write_addr   ( addr     ),
        .write_data   ( wdata    )
    );

    // Controller must present a clean index with every request
    addr_known_a: assert property (@(posedge clk) disable iff (!arst_n)
        req |-> !$isunknown(addr));

endmodule

/* rtl/register_file_1r_1w.sv */
/*
 * Flop-based memory with one write port and one read port.
 * Read data is captured on read_enable and holds otherwise,
 * so a caller can keep an output stable by not reading.
 */
`timescale 1ns/100ps

module register_file_1r_1w #(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,

    input  logic                  read_enable,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output logic [DATA_WIDTH-1:0] read_data,

    input  logic                  write_enable,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0] write_data
);

    // One row of flops per address
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, holds when idle
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* rtl/refill_if.sv */
/*
 * Link between the lookup controller and the refill unit.
 * The controller starts a line fetch with a valid/ready handshake;
 * the refill unit streams back words and pulses done after the last one.
 */
`timescale 1ns/100ps

interface refill_if import icache_cfg_pkg::*, icache_types_pkg::*; ();

    logic              start_valid;  // Line fetch request
    logic              start_ready;  // Refill unit idle
    icache_addr_t      line_addr;    // Address of the missing fetch
    logic              word_valid;   // One cycle per returned word
    logic [WORD_W-1:0] word_idx;
    logic [DATA_W-1:0] word_data;
    logic              done;         // Cycle after the last word

    modport ctrl (
        output start_valid, line_addr,
        input  start_ready, word_valid, word_idx, word_data, done
    );

    modport refill (
        input  start_valid, line_addr,
        output start_ready, word_valid, word_idx, word_data, done
    );

endinterface

/* rtl/icache_types_pkg.sv */
/*
 * Address types shared by the cache controller and refill unit.
 * A fetch address is written as one flat word and read back
 * through the field view (tag, set, word, byte offset).
 */
package icache_types_pkg;

    import icache_cfg_pkg::*;

    // Field view of a fetch address, MSB first
    typedef struct packed {
        logic [TAG_W-1:0]  tag;     // Compared against the tag array
        logic [SET_W-1:0]  set;     // Selects the line
        logic [WORD_W-1:0] word;    // Word inside the line
        logic [1:0]        offset;  // Byte offset, always zero for fetches
    } icache_addr_fields_t;

    // Same 32 bits, flat or split
    typedef union packed {
        logic [ADDR_W-1:0]   flat;
        icache_addr_fields_t f;
    } icache_addr_t;

endpackage

/* rtl/icache_cfg_pkg.sv */
/*
 * Geometry of the direct-mapped instruction cache.
 * Address split is tag[31:8], set[7:4], word[3:2], byte[1:0].
 * Imported by every block that sizes a port or an array.
 */
package icache_cfg_pkg;

    localparam int ADDR_W     = 32;            // Fetch address width
    localparam int DATA_W     = 32;            // Instruction word width
    localparam int WORD_W     = 2;             // Word select inside a line
    localparam int LINE_WORDS = 4;             // Words per line, one refill burst
    localparam int SET_W      = 4;             // Set index width
    localparam int NUM_SETS   = 1 << SET_W;    // 16 sets
    localparam int TAG_W      = 24;            // Address bits 31 to 8

    // Data array is indexed by set and word together
    localparam int DATA_RAM_AW = SET_W + WORD_W;

endpackage
